// ==== sim.f ====
+incdir+src
src/front_pkg.sv
src/instr_loader.sv
src/instr_decoder.sv
src/reg_renamer.sv
src/instr_issuer.sv
src/instr_processer.sv
test/clock_gen.sv
test/instr_processer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the front end with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module instr_processer_tb -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation binary exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== test/instr_processer_tb.sv ====
// ##############################
// Front-end testbench checking a random program against an in-order rename model
// Top of the Verilator run started by run_sim.sh
// ##############################
`timescale 1ns/1ps
`include "front_config.svh"

module instr_processer_tb import front_pkg::*; ();

  localparam int prog_words = 400;
  localparam int timeout_ns = prog_words * 8 * 4;

  localparam logic [6:0] legal_opc [5] = '{7'b0110011, 7'b0010011, 7'b0000011,
                                          7'b0100011, 7'b0110111};
  // JAL, branch, JALR and system words
  localparam logic [6:0] bad_opc [4] = '{7'b1101111, 7'b1100011, 7'b1100111, 7'b1110011};

  logic             clk;
  logic             rst;
  logic [`XLEN-1:0] fetch_addr;
  logic [63:0]      fetch_data;
  logic             rs_full;
  issue_t           issue [2];

  logic [31:0]       prog [prog_words];
  issue_t            exp_q [$];           // Expected issue order
  issue_t            prev [2];            // Outputs seen one cycle earlier
  logic              prev_full;
  logic              m_pend [`ARCH_REGS]; // Model rename table
  logic [`TAG_W-1:0] m_tag_of [`ARCH_REGS];
  logic [`TAG_W-1:0] m_next_tag;
  int                checks;
  int                errors;
  int                test_err;
  int                issued;
  int                legal;

  clock_gen clocks (
    .clk (clk),
    .rst (rst)
  );

  instr_processer UUT (
    .clk        (clk),
    .rst        (rst),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .rs_full    (rs_full),
    .issue      (issue)
  );

  // Always-hit cache model that reads zero past the program
  function automatic logic [31:0] mem_word(input logic [`XLEN-1:0] addr);
    return (addr[`XLEN-1:2] < prog_words) ? prog[addr[`XLEN-1:2]] : 32'h0;
  endfunction

  assign fetch_data = {mem_word(fetch_addr + 32'd4), mem_word(fetch_addr)};

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
    end
  endtask

  // ##############################
  // Program and reference model
  // ##############################
  function automatic logic [4:0] pick_reg();
    return ($urandom % 4 != 0) ? 5'($urandom % 8) : 5'($urandom % 32); // Mostly x0..x7
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w        = $urandom;
    w[11:7]  = pick_reg();
    w[19:15] = pick_reg();
    w[24:20] = pick_reg();
    w[6:0]   = ($urandom % 100 < 85) ? legal_opc[$urandom % 5] : bad_opc[$urandom % 4];
    return w;
  endfunction

  // Latest earlier writer, or ready when there is none
  function automatic operand_t source_operand(input logic [4:0] r, input logic used);
    operand_t o;
    o = '{ready: 1'b1, tag: '0};
    if (used && r != 5'd0 && m_pend[r]) o = '{ready: 1'b0, tag: m_tag_of[r]};
    return o;
  endfunction

  task automatic model_word(input logic [31:0] w);
    issue_t want;
    logic   u1;
    logic   u2;
    logic   wr;
    want = '0;
    u1   = 1'b1;
    u2   = 1'b0;
    wr   = 1'b1;
    case (w[6:0])
      7'b0110011: begin
        want.op       = op_alu;
        want.funct7_5 = w[30];
        u2            = 1'b1;
      end
      7'b0010011: begin
        want.op       = op_alu_imm;
        want.imm      = {{20{w[31]}}, w[31:20]};
        want.funct7_5 = (w[14:12] == 3'b101) && w[30]; // SRAI
      end
      7'b0000011: begin
        want.op  = op_load;
        want.imm = {{20{w[31]}}, w[31:20]};
      end
      7'b0100011: begin
        want.op  = op_store;
        want.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        u2       = 1'b1;
        wr       = 1'b0;
      end
      7'b0110111: begin
        want.op  = op_lui;
        want.imm = {w[31:12], 12'h0};
        u1       = 1'b0;
      end
      default: return; // Dropped by the front end
    endcase
    wr          = wr && (w[11:7] != 5'd0);
    want.valid  = 1'b1;
    want.funct3 = (want.op == op_lui) ? 3'd0 : w[14:12];
    want.rd     = wr ? w[11:7] : 5'd0;
    want.src1   = source_operand(w[19:15], u1);
    want.src2   = source_operand(w[24:20], u2);
    if (wr) begin
      want.dest_tag     = m_next_tag;
      m_pend[w[11:7]]   = 1'b1;
      m_tag_of[w[11:7]] = m_next_tag;
      m_next_tag        = m_next_tag + 1'b1; // Wraps after 63
    end
    exp_q.push_back(want);
    legal++;
  endtask

  // ##############################
  // One cycle of stimulus and checks
  // ##############################
  task automatic sample_cycle();
    issue_t want;
    @(negedge clk);
    if (prev_full && (prev[0].valid || prev[1].valid)) begin
      check_val("issue[0] held", issue[0], prev[0]);
      check_val("issue[1] held", issue[1], prev[1]);
    end
    rs_full = (($urandom % 10) < 3);
    if (!rs_full) begin
      for (int l = 0; l < 2; l++) begin
        if (issue[l].valid && exp_q.size() == 0) begin
          errors++;
          $display("[ERROR] %0t lane %0d issued an instruction nobody expected", $time, l);
        end else if (issue[l].valid) begin
          want = exp_q.pop_front(); // Lane 0 first keeps program order
          check_val($sformatf("issue[%0d]", l), issue[l], want);
          issued++;
        end
      end
    end
    prev      = issue;
    prev_full = rs_full;
  endtask

  task automatic report_test(input string name);
    $display("Test %-8s %s, %0d errors", name,
             (errors == test_err) ? "passed" : "FAILED", errors - test_err);
    test_err = errors;
  endtask

  initial begin
    rs_full    = 1'b0;
    prev_full  = 1'b0;
    checks     = 0;
    errors     = 0;
    test_err   = 0;
    issued     = 0;
    legal      = 0;
    m_next_tag = '0;
    for (int r = 0; r < `ARCH_REGS; r++) m_pend[r] = 1'b0;
    void'($urandom(32'hd61e_4c39));
    for (int i = 0; i < prog_words; i++) begin
      prog[i] = random_word();
      model_word(prog[i]);
    end

    // Reset cycles and the first cycle after
    do begin
      @(negedge clk);
      check_val("fetch_addr", fetch_addr, `START_PC);
      check_val("issue valid", {issue[1].valid, issue[0].valid}, 2'b00);
    end while (rst);
    report_test("reset");

    while (exp_q.size() != 0) sample_cycle();
    report_test("stream");

    repeat (8) sample_cycle(); // Two pipeline depths with nothing left to issue
    check_val("issue valid", {issue[1].valid, issue[0].valid}, 2'b00);
    report_test("drain");

    $display("Totals: %0d checks, %0d errors, %0d of %0d instructions issued",
             checks, errors, issued, legal);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== test/clock_gen.sv ====
// ##############################
// Testbench clock and reset, 8 ns period, reset held for 3 cycles
// ##############################
`timescale 1ns/1ps

module clock_gen #(
  parameter int half_period  = 4,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0; // Released on a rising edge
  end

endmodule

// ==== src/instr_processer.sv ====
// ##############################
// Front-end top, fetch to issue in four registered stages
// ##############################
`timescale 1ns/1ps
`include "front_config.svh"

module instr_processer import front_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  output logic [`XLEN-1:0] fetch_addr,
  input  logic [63:0]      fetch_data,
  input  logic             rs_full,
  output issue_t           issue [2]
);

  // ##############################
  // Stage links
  // ##############################
  logic     stall;
  fetch_t   slot [2];
  decoded_t dec  [2];
  issue_t   ren  [2];

  instr_loader loader (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .slot       (slot)
  );

  instr_decoder decoder_0 (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .slot  (slot[0]),
    .dec   (dec[0])
  );

  instr_decoder decoder_1 (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .slot  (slot[1]),
    .dec   (dec[1])
  );

  reg_renamer renamer (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .dec   (dec),
    .ren   (ren)
  );

  instr_issuer issuer (
    .clk     (clk),
    .rst     (rst),
    .rs_full (rs_full),
    .ren     (ren),
    .issue   (issue),
    .stall   (stall) // Fans out to every earlier stage
  );

endmodule

// ==== src/instr_issuer.sv ====
// ##############################
// Issue register, holds the pair while the reservation stations are full
// ##############################
`timescale 1ns/1ps

module instr_issuer import front_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   rs_full,
  input  issue_t ren [2],
  output issue_t issue [2],
  output logic   stall
);

  logic holding; // Some lane is waiting to be taken

  assign holding = issue[0].valid || issue[1].valid;

  // Only stage that looks at rs_full, everything upstream follows stall
  assign stall = holding && rs_full;

  always_ff @(posedge clk) begin
    if (rst) begin
      issue[0].valid <= 1'b0;
      issue[1].valid <= 1'b0;
    end else if (!stall) begin
      // An empty pair is loaded too, so a bubble clears the outputs
      issue <= ren;
    end
  end

endmodule

// ==== src/reg_renamer.sv ====
// ##############################
// Rename table and tag allocator for both lanes, resolves lane 1 on lane 0
// ##############################
`timescale 1ns/1ps
`include "front_config.svh"

module reg_renamer import front_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall,
  input  decoded_t dec [2],
  output issue_t   ren [2]
);

  logic              pending   [`ARCH_REGS]; // Set once a register has an in-flight writer
  logic [`TAG_W-1:0] tag_table [`ARCH_REGS];
  logic [`TAG_W-1:0] next_tag;

  logic              write   [2];
  logic [`TAG_W-1:0] new_tag [2];
  issue_t            ren_next [2];

  // Source lookup against the table only, unused or x0 reads as ready
  function automatic operand_t table_lookup(input logic [4:0] r, input logic used);
    operand_t res;
    res = '{ready: 1'b1, tag: '0};
    if (used && r != 5'd0 && pending[r]) begin
      res.ready = 1'b0;
      res.tag   = tag_table[r];
    end
    return res;
  endfunction

  assign write[0]   = dec[0].valid && dec[0].writes_rd;
  assign write[1]   = dec[1].valid && dec[1].writes_rd;
  assign new_tag[0] = next_tag;
  assign new_tag[1] = next_tag + `TAG_W'(write[0]); // Lane 0 allocates first

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      ren_next[i].valid    = dec[i].valid;
      ren_next[i].op       = dec[i].op;
      ren_next[i].funct3   = dec[i].funct3;
      ren_next[i].funct7_5 = dec[i].funct7_5;
      ren_next[i].imm      = dec[i].imm;
      ren_next[i].rd       = dec[i].rd;
      ren_next[i].dest_tag = write[i] ? new_tag[i] : '0;
      ren_next[i].src1     = table_lookup(dec[i].rs1, dec[i].uses_rs1);
      ren_next[i].src2     = table_lookup(dec[i].rs2, dec[i].uses_rs2);
    end

    // Intra-pair dependency, the table does not hold lane 0's tag yet
    if (write[0] && dec[1].uses_rs1 && dec[1].rs1 == dec[0].rd) begin
      ren_next[1].src1 = '{ready: 1'b0, tag: new_tag[0]};
    end
    if (write[0] && dec[1].uses_rs2 && dec[1].rs2 == dec[0].rd) begin
      ren_next[1].src2 = '{ready: 1'b0, tag: new_tag[0]};
    end
  end

  // ##############################
  // Control state
  // ##############################
  always_ff @(posedge clk) begin
    if (rst) begin
      next_tag   <= '0;
      ren[0].valid <= 1'b0;
      ren[1].valid <= 1'b0;
      for (int r = 0; r < `ARCH_REGS; r++) begin
        pending[r] <= 1'b0;
      end
    end else if (!stall) begin
      ren      <= ren_next;
      next_tag <= next_tag + `TAG_W'(write[0]) + `TAG_W'(write[1]); // Wraps at 64
      for (int l = 0; l < 2; l++) begin
        if (write[l]) pending[dec[l].rd] <= 1'b1;
      end
    end
  end

  // Tag table, lane 1 written last so it wins on the same rd
  always_ff @(posedge clk) begin
    if (!stall) begin
      for (int l = 0; l < 2; l++) begin
        if (write[l]) tag_table[dec[l].rd] <= new_tag[l];
      end
    end
  end

endmodule

// ==== src/instr_decoder.sv ====
// ##############################
// Single-lane RV32I decoder, instantiated once per fetch slot
// ##############################
`timescale 1ns/1ps
`include "front_config.svh"

module instr_decoder import front_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall,
  input  fetch_t   slot,
  output decoded_t dec
);

  // Major opcodes handled by this front end
  localparam logic [6:0] opc_alu     = 7'b0110011;
  localparam logic [6:0] opc_alu_imm = 7'b0010011;
  localparam logic [6:0] opc_load    = 7'b0000011;
  localparam logic [6:0] opc_store   = 7'b0100011;
  localparam logic [6:0] opc_lui     = 7'b0110111;

  logic [31:0]      ins;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_u;
  decoded_t         dec_next;

  assign ins   = slot.instr;
  assign imm_i = {{(`XLEN-12){ins[31]}}, ins[31:20]};
  assign imm_s = {{(`XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_u = {ins[31:12], 12'b0};

  always_comb begin
    dec_next    = '0;
    dec_next.op = op_illegal;
    case (ins[6:0])
      opc_alu: begin
        dec_next.op        = op_alu;
        dec_next.uses_rs1  = 1'b1;
        dec_next.uses_rs2  = 1'b1;
        dec_next.writes_rd = 1'b1;
      end
      opc_alu_imm: begin
        dec_next.op        = op_alu_imm;
        dec_next.imm       = imm_i;
        dec_next.uses_rs1  = 1'b1;
        dec_next.writes_rd = 1'b1;
      end
      opc_load: begin
        dec_next.op        = op_load;
        dec_next.imm       = imm_i;
        dec_next.uses_rs1  = 1'b1;
        dec_next.writes_rd = 1'b1;
      end
      opc_store: begin
        dec_next.op       = op_store;
        dec_next.imm      = imm_s;
        dec_next.uses_rs1 = 1'b1;
        dec_next.uses_rs2 = 1'b1;
      end
      opc_lui: begin
        dec_next.op        = op_lui;
        dec_next.imm       = imm_u;
        dec_next.writes_rd = 1'b1;
      end
      default: dec_next.op = op_illegal; // Jumps, branches and the rest are dropped
    endcase

    if (ins[11:7] == 5'd0) dec_next.writes_rd = 1'b0; // x0 is never renamed
    dec_next.valid = slot.valid && (dec_next.op != op_illegal);

    // Zero out fields the class does not use
    dec_next.rd     = dec_next.writes_rd ? ins[11:7] : 5'd0;
    dec_next.rs1    = dec_next.uses_rs1 ? ins[19:15] : 5'd0;
    dec_next.rs2    = dec_next.uses_rs2 ? ins[24:20] : 5'd0;
    dec_next.funct3 = (dec_next.op inside {op_lui, op_illegal}) ? 3'd0 : ins[14:12];
    // Bit 30 selects SUB/SRA, and SRAI only among the immediates
    dec_next.funct7_5 = (dec_next.op == op_alu) ||
                        (dec_next.op == op_alu_imm && ins[14:12] == 3'b101) ? ins[30] : 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else if (!stall) begin
      dec <= dec_next;
    end
  end

endmodule

// ==== src/instr_loader.sv ====
// ##############################
// Fetch stage, reads an aligned pair from the cache port each cycle
// ##############################
`timescale 1ns/1ps
`include "front_config.svh"

module instr_loader import front_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,
  output logic [`XLEN-1:0] fetch_addr,
  input  logic [63:0]      fetch_data, // Lane 0 in the low word
  output fetch_t           slot [2]
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pc_hi; // Address of the second word

  assign fetch_addr = pc;
  assign pc_hi      = pc + `XLEN'(4);

  // ##############################
  // PC, no branches so always +8
  // ##############################
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `START_PC;
    end else if (!stall) begin
      pc <= pc + `XLEN'(8);
    end
  end

  // ##############################
  // Slot registers
  // ##############################
  always_ff @(posedge clk) begin
    if (rst) begin
      slot[0].valid <= 1'b0;
      slot[1].valid <= 1'b0;
    end else if (!stall) begin
      // Cache always hits, so both words are good every cycle
      slot[0].valid   <= 1'b1;
      slot[0].address <= pc;
      slot[0].instr   <= fetch_data[31:0];
      slot[1].valid   <= 1'b1;
      slot[1].address <= pc_hi;
      slot[1].instr   <= fetch_data[63:32];
    end
  end

endmodule

// ==== src/front_pkg.sv ====
// ##############################
// Stage-to-stage types for the two-wide front end
// ##############################
`include "front_config.svh"

package front_pkg;

  // Instruction class, anything outside RV32I ALU/load/store/LUI is illegal
  typedef enum logic [2:0] {
    op_alu,     // R-type
    op_alu_imm, // I-type arithmetic
    op_load,
    op_store,
    op_lui,
    op_illegal
  } op_e;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] address;
    logic [31:0]      instr;
  } fetch_t;

  typedef struct packed {
    logic             valid;
    op_e              op;
    logic [2:0]       funct3;
    logic             funct7_5;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;       // Sign-extended
    logic             uses_rs1;
    logic             uses_rs2;
    logic             writes_rd; // Never set for x0
  } decoded_t;

  // Tag is zero whenever ready is set
  typedef struct packed {
    logic              ready;
    logic [`TAG_W-1:0] tag;
  } operand_t;

  typedef struct packed {
    logic              valid;
    op_e               op;
    logic [2:0]        funct3;
    logic              funct7_5;
    logic [`XLEN-1:0]  imm;
    logic [4:0]        rd;
    logic [`TAG_W-1:0] dest_tag;
    operand_t          src1;
    operand_t          src2;
  } issue_t;

endpackage

// ==== src/front_config.svh ====
// ##############################
// Front-end widths and reset PC, included by the package and every stage
// ##############################
`ifndef FRONT_CONFIG_SVH
`define FRONT_CONFIG_SVH

// Datapath
`define XLEN      32            // Data and address width
`define START_PC  32'h0000_0000 // First fetch address after reset

// Renaming
`define ARCH_REGS 32            // RV32I register file
`define TAG_W     6             // 64 tags, counter wraps

`endif
